// File: vlog.f
design/tagmem_pkg.sv
design/tagged_sram_1rw.sv
design/domain_guard.sv
design/scrub_engine.sv
design/tagged_mem_top.sv
verif/tagged_mem_tb.sv

// File: Makefile
# Verilator build and run of the tagged scratchpad testbench

TOP := tagged_mem_tb

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tagged_mem_tb.sv
/* Testbench for the tagged scratchpad. Drives random and directed requests
   and checks every response against a model of data, tags and scrub state */

`default_nettype none

module tagged_mem_tb import tagmem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------

  logic     clk;
  logic     rst;
  logic     req_valid;
  mem_req_t req;
  logic     scrub_start;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     scrub_busy;

  // Model of the storage contents and the scrub walk
  logic [DATA_BITS-1:0] data_m [NUM_ENTRIES];
  domain_t              tag_m  [NUM_ENTRIES];
  int                   busy_left;
  // Response expected on the next falling edge
  logic                 exp_valid;
  mem_rsp_t             exp_rsp;

  int value_errors;
  int timeout_errors;
  int checks;

  tagged_mem_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .scrub_start (scrub_start),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .scrub_busy  (scrub_busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      value_errors++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic mem_req_t make_req(input logic wr, input domain_t dom,
                                        input int addr, input logic [3:0] be,
                                        input logic [31:0] data);
    mem_req_t r;
    r.write   = wr;
    r.domain  = dom;
    r.addr    = ADDR_BITS'(addr);
    r.byte_en = be;
    r.wdata   = data;
    return r;
  endfunction

  // Most addresses land in entries 0 to 3 so that domains collide often
  function automatic mem_req_t random_req();
    mem_req_t    r;
    logic [31:0] rnd;
    rnd       = $urandom();
    r.write   = rnd[0];
    r.domain  = rnd[1];
    r.byte_en = rnd[5:2];
    if (rnd[9:8] != 2'b00) begin
      r.addr = ADDR_BITS'(rnd[11:10]);
    end else begin
      r.addr = rnd[15:12];
    end
    r.wdata = $urandom();
    return r;
  endfunction

  // One clock cycle, starting at a falling edge. Checks what the DUT shows
  // now, runs the model for the new inputs, drives them and moves on
  task automatic step(input logic v, input mem_req_t r, input logic ss);
    mem_rsp_t nxt;
    logic     exp_busy;
    int       widx;
    exp_busy = (busy_left != 0);
    check_field("scrub_busy", 32'(scrub_busy), 32'(exp_busy));
    check_field("rsp_valid", 32'(rsp_valid), 32'(exp_valid));
    if (exp_valid) begin
      check_field("rsp.status", 32'(rsp.status), 32'(exp_rsp.status));
      check_field("rsp.write", 32'(rsp.write), 32'(exp_rsp.write));
      check_field("rsp.rdata", rsp.rdata, exp_rsp.rdata);
      check_field("rsp.tag", 32'(rsp.tag), 32'(exp_rsp.tag));
    end
    nxt.write  = r.write;
    nxt.rdata  = '0;
    nxt.tag    = 1'b0;
    nxt.status = ST_BUSY;
    if (v && !exp_busy) begin
      nxt.tag = tag_m[r.addr];
      // Access needs a domain at least as high as the entry tag
      if (r.domain >= tag_m[r.addr]) begin
        nxt.status = ST_OK;
        if (r.write) begin
          for (int lane = 0; lane < DATA_BYTES; lane++) begin
            if (r.byte_en[lane]) begin
              data_m[r.addr][lane*BYTE_BITS +: BYTE_BITS] =
                r.wdata[lane*BYTE_BITS +: BYTE_BITS];
            end
          end
          // A write that touches no lane leaves the tag alone too
          if (r.byte_en != '0) begin
            tag_m[r.addr] = r.domain;
          end
        end else begin
          nxt.rdata = data_m[r.addr];
        end
      end else begin
        nxt.status = ST_DENIED;
      end
    end
    // Scrub clears one entry per busy cycle and ignores a strobe meanwhile
    if (exp_busy) begin
      widx         = NUM_ENTRIES - busy_left;
      data_m[widx] = '0;
      tag_m[widx]  = 1'b0;
      busy_left--;
    end else if (ss) begin
      busy_left = NUM_ENTRIES;
    end
    req_valid   = v;
    req         = r;
    scrub_start = ss;
    exp_valid   = v;
    exp_rsp     = nxt;
    @(negedge clk);
  endtask

  // Idles until the scrub ends, giving up after limit cycles
  task automatic wait_scrub_idle(input int limit);
    int cnt;
    cnt = 0;
    while (scrub_busy && cnt < limit) begin
      step(1'b0, '0, 1'b0);
      cnt++;
    end
    if (scrub_busy) begin
      timeout_errors++;
      $display("Timeout: scrub_busy stayed high for %0d cycles", limit);
    end
  endtask

  task automatic read_all(input domain_t dom);
    for (int a = 0; a < NUM_ENTRIES; a++) begin
      step(1'b1, make_req(1'b0, dom, a, 4'h0, 32'h0), 1'b0);
    end
  endtask

  // --------------------------------------------------
  // Test phases
  // --------------------------------------------------

  // Byte lanes, denial of low requests and retagging on entry 2
  task automatic directed_policy();
    step(1'b1, make_req(1'b1, 1'b0, 2, 4'b1111, 32'h1122_3344), 1'b0);
    step(1'b1, make_req(1'b1, 1'b0, 2, 4'b0010, 32'haabb_ccdd), 1'b0);
    step(1'b1, make_req(1'b0, 1'b0, 2, 4'b0000, 32'h0), 1'b0);
    step(1'b1, make_req(1'b1, 1'b1, 2, 4'b1000, 32'h5a00_0000), 1'b0);
    step(1'b1, make_req(1'b0, 1'b0, 2, 4'b0000, 32'h0), 1'b0);
    step(1'b1, make_req(1'b1, 1'b0, 2, 4'b1111, 32'hffff_ffff), 1'b0);
    step(1'b1, make_req(1'b0, 1'b1, 2, 4'b0000, 32'h0), 1'b0);
    // Back to back on the same entry, write then read
    step(1'b1, make_req(1'b1, 1'b1, 5, 4'b0101, 32'h0123_4567), 1'b0);
    step(1'b1, make_req(1'b0, 1'b1, 5, 4'b0000, 32'h0), 1'b0);
    step(1'b1, make_req(1'b0, 1'b0, 5, 4'b0000, 32'h0), 1'b0);
  endtask

  task automatic random_traffic(input int cycles);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++) begin
      rnd = $urandom();
      // Three requests in four cycles and a rare scrub strobe
      step(rnd[1:0] != 2'b00, random_req(), rnd[7:2] == 6'd0);
    end
  endtask

  // Every request inside a scrub is busy and the scrub leaves all zeros
  task automatic scrub_check();
    wait_scrub_idle(NUM_ENTRIES + 2);
    step(1'b0, '0, 1'b1);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      step(1'b1, random_req(), 1'b0);
    end
    wait_scrub_idle(4);
    read_all(1'b0);
    read_all(1'b1);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(40));
    rst            = 1'b1;
    req_valid      = 1'b0;
    req            = '0;
    scrub_start    = 1'b0;
    exp_valid      = 1'b0;
    exp_rsp        = '0;
    busy_left      = 0;
    value_errors   = 0;
    timeout_errors = 0;
    checks         = 0;
    for (int a = 0; a < NUM_ENTRIES; a++) begin
      data_m[a] = '0;
      tag_m[a]  = 1'b0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    // The walk after reset clears the whole array
    busy_left = NUM_ENTRIES;
    wait_scrub_idle(NUM_ENTRIES + 2);
    if (timeout_errors == 0) begin
      read_all(1'b0);
      read_all(1'b1);
      directed_policy();
      random_traffic(600);
      scrub_check();
    end
    // Collect the last response
    step(1'b0, '0, 1'b0);
    $display("Summary: %0d checks, %0d value errors, %0d timeouts",
             checks, value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/tagged_mem_top.sv
/* Tagged scratchpad top level. Connects the policy guard, the scrub
   engine and the storage, and picks the storage write source */

`default_nettype none

module tagged_mem_top import tagmem_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  // Request and response
  input  wire logic req_valid,
  input  mem_req_t  req,
  input  wire logic scrub_start,
  output logic      rsp_valid,
  output mem_rsp_t  rsp,
  output logic      scrub_busy
);

  // --------------------------------------------------
  // Internal nets
  // --------------------------------------------------

  logic [ADDR_BITS-1:0] read_addr;
  logic [DATA_BITS-1:0] read_data;
  domain_t              read_domain;
  sram_wr_t             guard_wr;
  sram_wr_t             scrub_wr;
  sram_wr_t             sram_wr;

  // The scrub engine owns the storage port for the whole walk
  assign sram_wr = scrub_busy ? scrub_wr : guard_wr;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------

  domain_guard u_guard (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .scrub_busy  (scrub_busy),
    .read_addr   (read_addr),
    .read_data   (read_data),
    .read_domain (read_domain),
    .wr          (guard_wr),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

  scrub_engine u_scrub (
    .clk         (clk),
    .rst         (rst),
    .scrub_start (scrub_start),
    .scrub_busy  (scrub_busy),
    .wr          (scrub_wr)
  );

  // Read address always comes from the guard, writes from the mux
  tagged_sram_1rw u_sram (
    .clk         (clk),
    .rst         (rst),
    .read_addr   (read_addr),
    .read_data   (read_data),
    .read_domain (read_domain),
    .wr          (sram_wr)
  );

endmodule

`default_nettype wire

// File: design/scrub_engine.sv
/* Scrub engine. Walks every entry after reset or on a scrub strobe,
   writing zero data with a low tag, one entry per cycle */

`default_nettype none

module scrub_engine import tagmem_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic scrub_start,
  output logic      scrub_busy,
  output sram_wr_t  wr
);

  // --------------------------------------------------
  // Address walk
  // --------------------------------------------------

  logic                 busy_q;
  logic [ADDR_BITS-1:0] addr_q;
  logic                 last_addr;

  assign last_addr = (addr_q == ADDR_BITS'(NUM_ENTRIES - 1));

  // Reset holds busy high so the walk starts as soon as reset drops
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b1;
      addr_q <= '0;
    end else if (busy_q) begin
      if (last_addr) begin
        busy_q <= 1'b0;
        addr_q <= '0;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end else if (scrub_start) begin
      // A strobe during a running walk falls through and is ignored
      busy_q <= 1'b1;
      addr_q <= '0;
    end
  end

  assign scrub_busy = busy_q;

  // --------------------------------------------------
  // Clearing write
  // --------------------------------------------------

  // Full word of zeros with the low tag, every cycle while busy
  always_comb begin
    wr.en      = busy_q;
    wr.addr    = addr_q;
    wr.byte_en = '1;
    wr.data    = '0;
    wr.domain  = 1'b0;
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The walk stays inside the array
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    busy_q |-> (int'(addr_q) <= NUM_ENTRIES - 1)
  ) else $error("scrub_engine: address counter passed the last entry");

endmodule

`default_nettype wire

// File: design/domain_guard.sv
/* Domain policy guard. Checks each request against the stored entry
   tag, issues allowed writes and registers the one-cycle response */

`default_nettype none

module domain_guard import tagmem_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // Requester side
  input  wire logic                 req_valid,
  input  mem_req_t                  req,
  input  wire logic                 scrub_busy,
  // Storage read port
  output logic      [ADDR_BITS-1:0] read_addr,
  input  wire logic [DATA_BITS-1:0] read_data,
  input  domain_t                   read_domain,
  // Storage write port
  output sram_wr_t                  wr,
  // Response side
  output logic                      rsp_valid,
  output mem_rsp_t                  rsp
);

  // --------------------------------------------------
  // Access decision
  // --------------------------------------------------

  logic     allowed;
  mem_rsp_t rsp_next;
  logic     rsp_valid_q;
  mem_rsp_t rsp_q;

  // The stored tag is looked up in the same cycle as the request
  assign read_addr = req.addr;

  // A request may touch an entry only from an equal or higher domain
  assign allowed = (req.domain >= read_domain);

  // Writes go out only when allowed and the scrub does not own the port
  // A write with no byte enables is a no-op and stays off the port
  always_comb begin
    wr.en      = req_valid && !scrub_busy && req.write && allowed &&
                 (|req.byte_en);
    wr.addr    = req.addr;
    wr.byte_en = req.byte_en;
    wr.data    = req.wdata;
    // An allowed write takes over the requester's domain
    wr.domain  = req.domain;
  end

  // --------------------------------------------------
  // Response formation
  // --------------------------------------------------

  always_comb begin
    rsp_next.write = req.write;
    rsp_next.rdata = '0;
    rsp_next.tag   = read_domain;
    if (scrub_busy) begin
      // Entries are being cleared so the tag seen here means nothing
      rsp_next.status = ST_BUSY;
      rsp_next.tag    = 1'b0;
    end else if (allowed) begin
      rsp_next.status = ST_OK;
      // Only an allowed read sees the stored word
      if (!req.write) begin
        rsp_next.rdata = read_data;
      end
    end else begin
      rsp_next.status = ST_DENIED;
    end
  end

  // --------------------------------------------------
  // Response register
  // --------------------------------------------------

  // Valid follows the strobe by exactly one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid;
    end
  end

  // Payload is only loaded by a strobed request
  always_ff @(posedge clk) begin
    if (req_valid) begin
      rsp_q <= rsp_next;
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The guard never competes with the scrub engine for the storage
  a_wr_only_when_owned: assert property (
    @(posedge clk) disable iff (rst)
    wr.en |-> (req_valid && !scrub_busy)
  ) else $error("domain_guard: write issued without a request or during scrub");

endmodule

`default_nettype wire

// File: design/tagged_sram_1rw.sv
/* Single-port tagged SRAM. Reads data and tag combinationally and
   writes enabled byte lanes plus the entry tag on the clock edge */

`default_nettype none

module tagged_sram_1rw import tagmem_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // Read port, combinational
  input  wire logic [ADDR_BITS-1:0] read_addr,
  output logic      [DATA_BITS-1:0] read_data,
  output domain_t                   read_domain,
  // Write port, sampled on the rising edge
  input  sram_wr_t                  wr
);

  // --------------------------------------------------
  // Storage arrays
  // --------------------------------------------------

  // Data is kept as one array per byte lane so that every lane
  // has its own write process
  logic [BYTE_BITS-1:0] data_mem [DATA_BYTES][NUM_ENTRIES];

  // One domain tag per entry
  domain_t tag_mem [NUM_ENTRIES];

  // The tag follows the entry whenever any lane is written
  logic tag_we;

  assign tag_we = wr.en && (|wr.byte_en);

  // --------------------------------------------------
  // Byte lanes
  // --------------------------------------------------

  for (genvar lane = 0; lane < DATA_BYTES; lane++) begin : g_lane
    // Read side of this lane, no enable and no latching
    assign read_data[lane*BYTE_BITS +: BYTE_BITS] = data_mem[lane][read_addr];

    // Write side of this lane, only when its byte enable is set
    always_ff @(posedge clk) begin
      if (wr.en && wr.byte_en[lane]) begin
        data_mem[lane][wr.addr] <= wr.data[lane*BYTE_BITS +: BYTE_BITS];
      end
    end
  end

  // --------------------------------------------------
  // Domain tags
  // --------------------------------------------------

  // Tag read shares the data read address
  assign read_domain = tag_mem[read_addr];

  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[wr.addr] <= wr.domain;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Both write sources must present at least one lane with the enable,
  // otherwise the tag would silently stay behind
  a_wr_has_lanes: assert property (
    @(posedge clk) disable iff (rst)
    wr.en |-> (wr.byte_en != '0)
  ) else $error("tagged_sram_1rw: write enable with no byte enables");

endmodule

`default_nettype wire

// File: design/tagmem_pkg.sv
/* Tagged scratchpad shared definitions. Holds the memory sizes, the
   request, response and storage write structs, and the status codes */

`default_nettype none

package tagmem_pkg;

  // --------------------------------------------------
  // Memory geometry
  // --------------------------------------------------

  // Number of words in the scratchpad
  localparam int NUM_ENTRIES = 16;
  // Word address width, sized from the entry count
  localparam int ADDR_BITS   = $clog2(NUM_ENTRIES);
  // Word width and byte lanes
  localparam int DATA_BITS   = 32;
  localparam int DATA_BYTES  = 4;
  // Width of one byte lane
  localparam int BYTE_BITS   = DATA_BITS / DATA_BYTES;

  // --------------------------------------------------
  // Security domains and status
  // --------------------------------------------------

  // Low domain is 0 and high domain is 1
  typedef logic domain_t;

  // Response status returned with every request
  typedef enum logic [1:0] {
    ST_OK     = 2'd0,
    ST_DENIED = 2'd1,
    ST_BUSY   = 2'd2
  } status_t;

  // --------------------------------------------------
  // Request, response and storage write port
  // --------------------------------------------------

  // One request from the single requester port
  typedef struct packed {
    logic                  write;
    domain_t               domain;
    logic [ADDR_BITS-1:0]  addr;
    logic [DATA_BYTES-1:0] byte_en;
    logic [DATA_BITS-1:0]  wdata;
  } mem_req_t;

  // Registered answer, one cycle after the request
  typedef struct packed {
    status_t              status;
    logic                 write;
    logic [DATA_BITS-1:0] rdata;
    // Tag of the entry before the access took place
    domain_t              tag;
  } mem_rsp_t;

  // Write port of the storage, driven by the guard or the scrub engine
  typedef struct packed {
    logic                  en;
    logic [ADDR_BITS-1:0]  addr;
    logic [DATA_BYTES-1:0] byte_en;
    logic [DATA_BITS-1:0]  data;
    domain_t               domain;
  } sram_wr_t;

endpackage

`default_nettype wire
